/* hw/pyon_pkg.sv */
package pyon_pkg;

  // ----------------------------------------------------------------------
  // widths that carry a meaning
  // ----------------------------------------------------------------------
  typedef logic [3:0]  bcd_digit_t;    // one decimal digit, 0..9
  typedef logic [6:0]  seg7_t;         // segments g..a, active low
  typedef logic [32:0] course_t;       // whole course, one bit per box
  typedef logic [7:0]  course_view_t;  // next eight boxes for the leds
  typedef logic [1:0]  speed_t;        // cpu rate select

  // ----------------------------------------------------------------------
  // course
  // ----------------------------------------------------------------------
  // bit 0 is the box under the player and a 1 means the right switch
  localparam course_t course_pattern = 33'b0_1101_0001_0101_1101_1001_0110_1000_1001;

  // ----------------------------------------------------------------------
  // scores
  // ----------------------------------------------------------------------
  localparam bcd_digit_t start_tens = 4'd3;  // both sides start at 32
  localparam bcd_digit_t start_ones = 4'd2;

  // ----------------------------------------------------------------------
  // pacing
  // ----------------------------------------------------------------------
  // a unit is 1/30 s on the board, the top level scales it down for sim
  localparam int unsigned timer_units = 30;  // one timer second

  // cpu step period per speed select, in units
  localparam int unsigned cpu_units [4] = '{
    20,  // 00  1.5 Hz
    15,  // 01  2 Hz
    10,  // 10  3 Hz
    6    // 11  5 Hz
  };

endpackage

/* hw/race_if.sv */
`timescale 1ns/1ps

interface race_if;

  pyon_pkg::bcd_digit_t player_tens;  // player boxes left
  pyon_pkg::bcd_digit_t player_ones;
  pyon_pkg::bcd_digit_t cpu_tens;     // cpu boxes left
  pyon_pkg::bcd_digit_t cpu_ones;
  pyon_pkg::bcd_digit_t time_tens;    // seconds since the race began
  pyon_pkg::bcd_digit_t time_ones;
  logic                 player_won;   // player went past zero first
  logic                 cpu_won;      // cpu went past zero first

  modport source (  // race_stage owns the counts
    output player_tens, player_ones,
    output cpu_tens, cpu_ones,
    output time_tens, time_ones,
    output player_won, cpu_won
  );

  modport sink (  // result_stage only looks
    input player_tens, player_ones,
    input cpu_tens, cpu_ones,
    input time_tens, time_ones,
    input player_won, cpu_won
  );

endinterface

/* hw/course_stage.sv */
`timescale 1ns/1ps

module course_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   new_game,    // reloads the course
  input  logic                   enable,      // race switch
  input  logic                   left,        // left player switch
  input  logic                   right,       // right player switch
  input  logic                   race_over,   // freeze once someone won
  output logic                   step,        // one pulse per correct flip
  output logic                   course_done, // all boxes stepped
  output pyon_pkg::course_view_t course_leds, // next eight boxes
  output logic                   cue_left,    // current box is on the left
  output logic                   cue_right    // current box is on the right
);

  localparam int unsigned box_count = $bits(pyon_pkg::course_t);  // 33 boxes
  typedef logic [$clog2(box_count + 1) - 1:0] box_cnt_t;

  pyon_pkg::course_t course_q;    // box 0 is the one to step on now
  box_cnt_t          boxes_left;  // steps still to go
  logic              cur_box;     // side of the current box
  logic              match;       // matching switch is up
  logic              match_q;     // registered match
  logic              match_d;     // match one cycle older, for the edge

  assign cur_box = course_q[0];
  assign match   = cur_box ? right : left;  // 1 = right, 0 = left

  // ----------------------------------------------------------------------
  // switch match and edge detect
  // ----------------------------------------------------------------------
  // match keeps tracking through new_game so a switch held across the
  // restart does not give a free step
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      match_q <= 1'b0;
      match_d <= 1'b0;
    end else begin
      match_q <= match;    // sample the switch
      match_d <= match_q;  // delayed copy
    end
  end

  // rising edge of the match, only while the race can take it
  assign step = match_q & ~match_d & enable & ~race_over & ~new_game;

  // ----------------------------------------------------------------------
  // course shift register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      course_q   <= pyon_pkg::course_pattern;  // fresh course
      boxes_left <= box_cnt_t'(box_count);
    end else if (new_game) begin
      course_q   <= pyon_pkg::course_pattern;  // restart reloads too
      boxes_left <= box_cnt_t'(box_count);
    end else if (step) begin
      course_q <= {1'b0, course_q[box_count-1:1]};  // next box moves under the player
      if (!course_done) begin
        boxes_left <= boxes_left - 1'b1;
      end
    end
  end

  assign course_done = (boxes_left == '0);

  // ----------------------------------------------------------------------
  // lights
  // ----------------------------------------------------------------------
  assign course_leds = course_q[7:0];  // led 0 is the current box
  assign cue_right   = cur_box;
  assign cue_left    = ~cur_box;

endmodule

/* hw/pace_gen.sv */
`timescale 1ns/1ps

module pace_gen #(
  parameter int unsigned unit_cycles = 1  // clk cycles per unit, at least 1
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             new_game,    // restart both dividers
  input  logic             enable,      // race switch
  input  logic             race_over,   // stop ticking after a win
  input  pyon_pkg::speed_t speed,       // cpu rate select
  output logic             timer_tick,  // one pulse per second
  output logic             cpu_tick     // one pulse per cpu step
);

  // timer period is the longest of all, so it sets the counter width
  localparam int unsigned timer_period = pyon_pkg::timer_units * unit_cycles;
  localparam int unsigned cnt_w        = $clog2(timer_period);
  typedef logic [cnt_w-1:0] cnt_t;

  localparam cnt_t timer_reload = cnt_t'(timer_period - 1);

  cnt_t timer_cnt;   // counts down to the next second
  cnt_t cpu_cnt;     // counts down to the next cpu step
  cnt_t cpu_reload;  // period for the selected speed
  logic run;         // dividers advance

  assign run        = enable & ~race_over;
  assign cpu_reload = cnt_t'(pyon_pkg::cpu_units[speed] * unit_cycles - 1);

  assign timer_tick = run & (timer_cnt == '0);  // last cycle of the period
  assign cpu_tick   = run & (cpu_cnt == '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      timer_cnt <= timer_reload;
      cpu_cnt   <= cpu_reload;
    end else if (new_game) begin
      timer_cnt <= timer_reload;  // race starts on a whole period
      cpu_cnt   <= cpu_reload;
    end else if (run) begin
      timer_cnt <= timer_tick ? timer_reload : timer_cnt - 1'b1;
      cpu_cnt   <= cpu_tick ? cpu_reload : cpu_cnt - 1'b1;  // new speed takes on reload
    end
  end

endmodule

/* hw/race_stage.sv */
`timescale 1ns/1ps

module race_stage (
  input  logic   clk,
  input  logic   reset,
  input  logic   new_game,     // back to 32 / 32 / 00
  input  logic   step,         // player stepped onto the next box
  input  logic   course_done,  // no boxes left on the course
  input  logic   timer_tick,   // one second passed
  input  logic   cpu_tick,     // cpu takes a box
  race_if.source race,         // counts and flags out
  output logic   race_over     // either side has won
);

  pyon_pkg::bcd_digit_t p_tens, p_ones;  // player boxes left
  pyon_pkg::bcd_digit_t c_tens, c_ones;  // cpu boxes left
  pyon_pkg::bcd_digit_t t_tens, t_ones;  // race time in seconds
  logic player_won;
  logic cpu_won;
  logic player_hit;   // step that still has a box under it
  logic player_zero;  // player at 00
  logic cpu_zero;     // cpu at 00

  // ----------------------------------------------------------------------
  // bcd helpers
  // ----------------------------------------------------------------------
  function automatic logic [7:0] bcd_dec(input pyon_pkg::bcd_digit_t tens,
                                         input pyon_pkg::bcd_digit_t ones);
    logic [7:0] res;
    if (ones == 4'd0) begin
      res = {tens - 4'd1, 4'd9};  // borrow from the tens
    end else begin
      res = {tens, ones - 4'd1};
    end
    return res;
  endfunction

  function automatic logic [7:0] bcd_inc(input pyon_pkg::bcd_digit_t tens,
                                         input pyon_pkg::bcd_digit_t ones);
    logic [7:0] res;
    if (ones != 4'd9) begin
      res = {tens, ones + 4'd1};
    end else if (tens != 4'd9) begin
      res = {tens + 4'd1, 4'd0};  // carry into the tens
    end else begin
      res = 8'h00;                // 99 wraps to 00
    end
    return res;
  endfunction

  assign player_hit  = step & ~course_done;
  assign player_zero = (p_tens == 4'd0) && (p_ones == 4'd0);
  assign cpu_zero    = (c_tens == 4'd0) && (c_ones == 4'd0);
  assign race_over   = player_won | cpu_won;

  // ----------------------------------------------------------------------
  // countdowns, timer and end flags
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      {p_tens, p_ones} <= {pyon_pkg::start_tens, pyon_pkg::start_ones};
      {c_tens, c_ones} <= {pyon_pkg::start_tens, pyon_pkg::start_ones};
      {t_tens, t_ones} <= 8'h00;
      player_won       <= 1'b0;
      cpu_won          <= 1'b0;
    end else if (new_game) begin
      {p_tens, p_ones} <= {pyon_pkg::start_tens, pyon_pkg::start_ones};
      {c_tens, c_ones} <= {pyon_pkg::start_tens, pyon_pkg::start_ones};
      {t_tens, t_ones} <= 8'h00;
      player_won       <= 1'b0;
      cpu_won          <= 1'b0;
    end else if (!race_over) begin  // everything freezes after a win
      if (player_hit) begin
        if (player_zero) begin
          player_won <= 1'b1;  // stepped past the last box
        end else begin
          {p_tens, p_ones} <= bcd_dec(p_tens, p_ones);
        end
      end
      if (cpu_tick) begin
        if (!cpu_zero) begin
          {c_tens, c_ones} <= bcd_dec(c_tens, c_ones);
        end else if (!(player_hit && player_zero)) begin
          cpu_won <= 1'b1;  // a tie goes to the player
        end
      end
      if (timer_tick) begin
        {t_tens, t_ones} <= bcd_inc(t_tens, t_ones);
      end
    end
  end

  assign race.player_tens = p_tens;
  assign race.player_ones = p_ones;
  assign race.cpu_tens    = c_tens;
  assign race.cpu_ones    = c_ones;
  assign race.time_tens   = t_tens;
  assign race.time_ones   = t_ones;
  assign race.player_won  = player_won;
  assign race.cpu_won     = cpu_won;

endmodule

/* hw/result_stage.sv */
`timescale 1ns/1ps

module result_stage (
  input  logic            clk,
  input  logic            reset,
  race_if.sink            race,  // counts and flags from the race
  output pyon_pkg::seg7_t hex0,  // time ones
  output pyon_pkg::seg7_t hex1,  // time tens
  output pyon_pkg::seg7_t hex2,  // best time ones
  output pyon_pkg::seg7_t hex3,  // best time tens
  output pyon_pkg::seg7_t hex4,  // cpu ones
  output pyon_pkg::seg7_t hex5,  // cpu tens
  output pyon_pkg::seg7_t hex6,  // player ones
  output pyon_pkg::seg7_t hex7   // player tens
);

  pyon_pkg::bcd_digit_t best_tens, best_ones;  // lowest winning time, 00 = none yet
  logic won_d;     // player_won one cycle late
  logic win_rise;  // player has just won
  logic faster;    // race time beats the best time

  // ----------------------------------------------------------------------
  // best time
  // ----------------------------------------------------------------------
  assign win_rise = race.player_won & ~won_d;
  assign faster   = (race.time_tens < best_tens) ||
                    ((race.time_tens == best_tens) && (race.time_ones < best_ones));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      won_d     <= 1'b0;
      best_tens <= 4'd0;
      best_ones <= 4'd0;
    end else begin
      won_d <= race.player_won;
      if (win_rise && ((best_tens == 4'd0 && best_ones == 4'd0) || faster)) begin
        best_tens <= race.time_tens;  // timer is frozen by now
        best_ones <= race.time_ones;
      end
    end
  end

  // ----------------------------------------------------------------------
  // seven-segment decode
  // ----------------------------------------------------------------------
  function automatic pyon_pkg::seg7_t seg_decode(input pyon_pkg::bcd_digit_t d);
    case (d)
      4'd0:    seg_decode = 7'b100_0000;
      4'd1:    seg_decode = 7'b111_1001;
      4'd2:    seg_decode = 7'b010_0100;
      4'd3:    seg_decode = 7'b011_0000;
      4'd4:    seg_decode = 7'b001_1001;
      4'd5:    seg_decode = 7'b001_0010;
      4'd6:    seg_decode = 7'b000_0010;
      4'd7:    seg_decode = 7'b111_1000;
      4'd8:    seg_decode = 7'b000_0000;
      4'd9:    seg_decode = 7'b001_0000;
      default: seg_decode = 7'b100_0000;  // not a digit, show 0
    endcase
  endfunction

  assign hex0 = seg_decode(race.time_ones);
  assign hex1 = seg_decode(race.time_tens);
  assign hex2 = seg_decode(best_ones);
  assign hex3 = seg_decode(best_tens);
  assign hex4 = seg_decode(race.cpu_ones);
  assign hex5 = seg_decode(race.cpu_tens);
  assign hex6 = seg_decode(race.player_ones);
  assign hex7 = seg_decode(race.player_tens);

endmodule

/* hw/pyon_top.sv */
`timescale 1ns/1ps

module pyon_top #(
  parameter int unsigned unit_cycles = 1666667  // 50 MHz / 30
) (
  input  logic                   clk,
  input  logic                   reset,       // also clears the best time
  input  logic                   new_game,    // restart the race
  input  logic                   enable,      // race runs while high
  input  pyon_pkg::speed_t       speed,       // cpu rate
  input  logic                   left,        // left switch
  input  logic                   right,       // right switch
  output pyon_pkg::seg7_t        hex0, hex1, hex2, hex3,
  output pyon_pkg::seg7_t        hex4, hex5, hex6, hex7,
  output pyon_pkg::course_view_t course_leds, // next eight boxes
  output logic                   cue_left,
  output logic                   cue_right,
  output logic                   player_won,
  output logic                   cpu_won
);

  logic step;         // correct switch flipped
  logic course_done;  // course used up
  logic timer_tick;   // one second
  logic cpu_tick;     // cpu step
  logic race_over;    // freeze everything

  race_if race_bus ();  // race state to the display side

  course_stage u_course (
    .clk         (clk),
    .reset       (reset),
    .new_game    (new_game),
    .enable      (enable),
    .left        (left),
    .right       (right),
    .race_over   (race_over),
    .step        (step),
    .course_done (course_done),
    .course_leds (course_leds),
    .cue_left    (cue_left),
    .cue_right   (cue_right)
  );

  pace_gen #(.unit_cycles(unit_cycles)) u_pace (
    .clk        (clk),
    .reset      (reset),
    .new_game   (new_game),
    .enable     (enable),
    .race_over  (race_over),
    .speed      (speed),
    .timer_tick (timer_tick),
    .cpu_tick   (cpu_tick)
  );

  race_stage u_race (
    .clk(clk), .reset(reset), .new_game(new_game), .step(step),
    .course_done(course_done), .timer_tick(timer_tick), .cpu_tick(cpu_tick),
    .race(race_bus.source), .race_over(race_over)
  );

  result_stage u_result (
    .clk(clk), .reset(reset), .race(race_bus.sink),
    .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
    .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7)
  );

  assign player_won = race_bus.player_won;  // end flags to the leds
  assign cpu_won    = race_bus.cpu_won;

endmodule

/* tests/pyon_props.sv */
`timescale 1ns/1ps

module pyon_props (
  input logic clk,
  input logic reset,
  input logic step,        // from course_stage
  input logic race_over,
  input logic player_won,
  input logic cpu_won
);

  // step is a one-cycle pulse
  step_single: assert property (@(posedge clk) disable iff (reset)
    !(step && $past(step)))
    else $error("step stayed high for two cycles");

  // the race has one winner
  one_winner: assert property (@(posedge clk) disable iff (reset)
    !(player_won && cpu_won))
    else $error("player_won and cpu_won are high together");

  // frozen course once the race is over
  no_late_step: assert property (@(posedge clk) disable iff (reset)
    !(step && race_over))
    else $error("step pulse while race_over is high");

endmodule

bind race_stage pyon_props u_props (
  .clk        (clk),
  .reset      (reset),
  .step       (step),
  .race_over  (race_over),
  .player_won (player_won),
  .cpu_won    (cpu_won)
);

/* tests/pyon_tb.sv */
`timescale 1ns/1ps

module pyon_tb;

  localparam int clk_period   = 4;
  localparam int unit_cycles  = 2;
  localparam int timer_period = 30 * unit_cycles;  // one race second
  localparam int fast_period  = 6 * unit_cycles;   // cpu at speed 3
  localparam int slow_period  = 20 * unit_cycles;  // cpu at speed 0
  localparam int settle       = 6;                 // cycles from a change to its check
  localparam int max_entries  = 66;                // a correct and maybe a wrong one per box
  localparam int pace_cycles  = 150;
  localparam int hold_cycles  = 130;
  localparam int cpu_wait     = 33 * fast_period + 40;
  localparam int test_cycles  = 20 + pace_cycles + max_entries * 2 * settle + hold_cycles
                              + cpu_wait + 100;

  localparam logic [32:0] course = 33'b0_1101_0001_0101_1101_1001_0110_1000_1001;
  localparam logic [6:0] seg_table [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                                            7'h12, 7'h02, 7'h78, 7'h00, 7'h10};

  logic       clk, reset, new_game, enable, left, right;
  logic [1:0] speed;
  logic [6:0] hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;
  logic [7:0] course_leds;
  logic       cue_left, cue_right, player_won, cpu_won;

  logic [2:0]  step_table [max_entries];  // {left, right, step expected}
  int          entries, errors, checks, steps;
  int unsigned lcg_state = 15590;

  pyon_top #(.unit_cycles(unit_cycles)) UUT (
    .clk(clk), .reset(reset), .new_game(new_game), .enable(enable), .speed(speed),
    .left(left), .right(right),
    .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
    .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7),
    .course_leds(course_leds), .cue_left(cue_left), .cue_right(cue_right),
    .player_won(player_won), .cpu_won(cpu_won)
  );

  // ----------------------------------------------------------------------
  // clock and watchdog
  // ----------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(2 * test_cycles * clk_period);
    $display("watchdog expired, the tests did not finish within %0d cycles", 2 * test_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;  // high bits are the better ones
  endfunction

  function automatic int seg_value(input logic [6:0] seg);
    int val;
    val = -100;  // not a digit, ruins the score on purpose
    for (int d = 0; d < 10; d++) begin
      if (seg_table[d] == seg) val = d;
    end
    return val;
  endfunction

  function automatic int shown(input logic [6:0] tens, input logic [6:0] ones);
    return seg_value(tens) * 10 + seg_value(ones);
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;  // drive and sample just after the edge
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_near(input string name, input int got, input int exp);
    checks++;
    if (got < exp - 1 || got > exp + 1) begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h within one", name, got, exp);
    end
  endtask

  task automatic check_course(input int done);
    logic [32:0] rest;
    rest = course >> done;  // boxes still ahead
    check_value("player score", shown(hex7, hex6), (done > 32) ? 0 : 32 - done);
    check_value("course_leds", course_leds, rest[7:0]);
    check_value("cue_right", cue_right, rest[0]);
    check_value("cue_left", cue_left, rest[0] ? 0 : 1);
  endtask

  task automatic restart();
    new_game = 1'b1;
    wait_cycles(2);
    new_game = 1'b0;
    wait_cycles(1);
    check_course(0);
    check_value("cpu score", shown(hex5, hex4), 32);
    check_value("race time", shown(hex1, hex0), 0);
  endtask

  task automatic build_table();
    entries = 0;
    for (int box = 0; box < 33; box++) begin
      if (next_random() % 2 == 1) begin
        step_table[entries] = {course[box], ~course[box], 1'b0};  // wrong side
        entries++;
      end
      step_table[entries] = {~course[box], course[box], 1'b1};
      entries++;
    end
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    int exp_time, exp_cpu, race_end, run_cycles, waited;
    reset = 1'b1;
    new_game = 1'b0;
    enable = 1'b0;
    speed = 2'd3;
    left = 1'b0;
    right = 1'b0;
    errors = 0;
    checks = 0;
    steps = 0;
    run_cycles = 0;
    build_table();
    wait_cycles(10);
    reset = 1'b0;
    wait_cycles(2);
    check_course(0);  // fresh board
    check_value("cpu score", shown(hex5, hex4), 32);
    check_value("race time", shown(hex1, hex0), 0);
    check_value("best time", shown(hex3, hex2), 0);

    enable = 1'b1;  // cpu runs alone at speed 3
    wait_cycles(pace_cycles);
    enable = 1'b0;
    wait_cycles(2);
    check_near("cpu score", shown(hex5, hex4), 32 - pace_cycles / fast_period);

    speed = 2'd0;  // slow cpu so the player wins
    restart();
    enable = 1'b1;
    for (int i = 0; i < entries; i++) begin
      {left, right} = step_table[i][2:1];
      wait_cycles(settle);
      if (step_table[i][0]) steps++;
      check_course(steps);  // held switch gives one step only
      left = 1'b0;
      right = 1'b0;
      wait_cycles(settle);
      check_course(steps);
      run_cycles += 2 * settle;
    end

    check_value("player_won", player_won, 1);
    check_value("cpu_won", cpu_won, 0);
    race_end = run_cycles - 2 * settle + 2;  // win lands two edges after the last flip
    exp_time = race_end / timer_period;
    exp_cpu  = 32 - race_end / slow_period;
    check_value("race time", shown(hex1, hex0), exp_time);
    check_value("cpu score", shown(hex5, hex4), exp_cpu);
    wait_cycles(hold_cycles);
    check_value("race time", shown(hex1, hex0), exp_time);
    check_value("cpu score", shown(hex5, hex4), exp_cpu);
    check_value("best time", shown(hex3, hex2), exp_time);

    speed = 2'd3;  // now the cpu takes the race
    restart();
    check_value("best time", shown(hex3, hex2), exp_time);
    check_value("player_won", player_won, 0);
    waited = 0;
    while (!cpu_won && waited < cpu_wait) begin
      wait_cycles(1);
      waited++;
    end
    if (!cpu_won) begin
      errors++;
      $display("cpu_won never rose while the cpu raced at speed 3");
    end
    check_near("cpu win ticks", waited / fast_period, 33);
    check_value("player_won", player_won, 0);
    for (int i = 0; i < 3; i++) begin  // steps after the loss do nothing
      {left, right} = {~course[0], course[0]};
      wait_cycles(settle);
      left = 1'b0;
      right = 1'b0;
      wait_cycles(settle);
      check_course(0);
      check_value("best time", shown(hex3, hex2), exp_time);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* pyon_top.f */
hw/pyon_pkg.sv
hw/race_if.sv
hw/course_stage.sv
hw/pace_gen.sv
hw/race_stage.sv
hw/result_stage.sv
hw/pyon_top.sv
tests/pyon_props.sv
tests/pyon_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module pyon_tb -f pyon_top.f -o pyon_sim 2>&1 | tee build.log

./obj_dir/pyon_sim 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
exit 0
